// ==== Makefile ====
# Verilator build and run of the execute stage testbench.

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module tb_exe -o tb_exe
	out="$$(./obj_dir/tb_exe)"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+tests
common/exe_pkg.sv
logic/alu.sv
logic/branch_unit.sv
exe/exe_unit.sv
exe/exe_stage.sv
tests/tb_exe.sv

// ==== common/exe_pkg.sv ====
// Shared widths, RV64I opcode and function codes, and the execute stage payload structs.
// Only the base integer set is covered. M extension, CSR and system opcodes are absent.
`default_nettype none

package exe_pkg;

  localparam int xlen = 64;

  // major opcodes, instruction bits 6:0.
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm_w  = 7'b0011011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_reg_w  = 7'b0111011;

  // integer operation funct3 codes.
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // conditional branch funct3 codes.
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // funct7 that selects sub and sra.
  localparam logic [6:0] f7_alt = 7'b0100000;

  // one instruction as handed over by decode.
  typedef struct packed {
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] op1;     // rs1 value, or pc/zero for auipc/lui.
    logic [xlen-1:0] op2;     // rs2 value or the immediate.
    logic [xlen-1:0] t1;      // branch/jal target or the jalr offset.
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_pred; // next pc assumed by fetch.
    logic            memren;
    logic            memwen;
  } decoded_t;

  // one executed result offered downstream.
  typedef struct packed {
    logic            pc_jmp;      // fetch must redirect to pc_jmpaddr.
    logic [xlen-1:0] pc_jmpaddr;
    logic            rd_wen;
    logic [xlen-1:0] rd_wdata;
    logic            memren;
    logic            memwen;
    logic [xlen-1:0] mem_addr;
  } executed_t;

endpackage

`default_nettype wire

// ==== exe/exe_stage.sv ====
// Execute stage with a one-entry slot between the decode and downstream req/ack pairs.
// One cycle latency, full throughput while the downstream ack stays high.
`timescale 1ns/1ns
`default_nettype none

module exe_stage
  import exe_pkg::*;
(
  input  wire           clk,
  input  wire           rst,

  input  wire           i_decoded_req,
  output logic          o_decoded_ack,
  input  wire decoded_t i_decoded,

  output logic          o_executed_req,
  input  wire           i_executed_ack,
  output executed_t     o_executed
);

  logic      full;
  decoded_t  slot;
  executed_t result;
  logic      put;
  logic      take;

  // the slot can take a new entry if it is empty or is being drained this cycle.
  assign o_decoded_ack = ~full | i_executed_ack;
  assign put           = i_decoded_req & o_decoded_ack;

  assign o_executed_req = full;
  assign take           = full & i_executed_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (put) begin
      full <= 1'b1;                 // refill wins over a drain in the same cycle.
    end else if (take) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (put) begin
      slot <= i_decoded;
    end
  end

  exe_unit u_exe_unit (
    .i_inst   (slot),
    .o_result (result)
  );

  // Control bits must not look valid while nothing is held.
  always_comb begin
    o_executed        = result;
    o_executed.pc_jmp = result.pc_jmp & full;
    o_executed.rd_wen = result.rd_wen & full;
    o_executed.memren = result.memren & full;
    o_executed.memwen = result.memwen & full;
  end

endmodule

`default_nettype wire

// ==== exe/exe_unit.sv ====
// Combinational execution of one decoded instruction into an executed result.
// Loads and stores only get their address here. The access is done downstream.
`timescale 1ns/1ns
`default_nettype none

module exe_unit
  import exe_pkg::*;
(
  input  wire decoded_t i_inst,
  output executed_t     o_result
);

  logic            is_word;
  logic            is_reg;
  logic            is_jump;
  logic            is_upper;
  logic            no_rd;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] link;
  logic [xlen-1:0] op_sum;
  logic            pc_jmp;
  logic [xlen-1:0] pc_jmpaddr;

  assign is_word  = (i_inst.opcode == op_imm_w) | (i_inst.opcode == op_reg_w);
  assign is_reg   = (i_inst.opcode == op_reg) | (i_inst.opcode == op_reg_w);
  assign is_jump  = (i_inst.opcode == op_jal) | (i_inst.opcode == op_jalr);
  assign is_upper = (i_inst.opcode == op_lui) | (i_inst.opcode == op_auipc);
  assign no_rd    = (i_inst.opcode == op_branch) | (i_inst.opcode == op_store);

  // shared by lui/auipc and the load/store address.
  assign op_sum = i_inst.op1 + i_inst.op2;

  alu u_alu (
    .i_funct3 (i_inst.funct3),
    .i_funct7 (i_inst.funct7),
    .i_word   (is_word),
    .i_reg    (is_reg),
    .i_op1    (i_inst.op1),
    .i_op2    (i_inst.op2),
    .o_result (alu_result)
  );

  branch_unit u_branch_unit (
    .i_inst       (i_inst),
    .o_pc_jmp     (pc_jmp),
    .o_pc_jmpaddr (pc_jmpaddr),
    .o_link       (link)
  );

  always_comb begin
    o_result.pc_jmp     = pc_jmp;
    o_result.pc_jmpaddr = pc_jmpaddr;
    o_result.rd_wen     = ~no_rd;
    if (is_jump) begin
      o_result.rd_wdata = link;
    end else if (is_upper) begin
      o_result.rd_wdata = op_sum;  // decode puts pc (auipc) or zero (lui) in op1.
    end else begin
      o_result.rd_wdata = alu_result;
    end
    o_result.memren   = i_inst.memren;
    o_result.memwen   = i_inst.memwen;
    o_result.mem_addr = op_sum;
  end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
// RV64I integer ALU, purely combinational.
// Word forms work on the low 32 bits and return the sign-extended result.
`timescale 1ns/1ns
`default_nettype none

module alu
  import exe_pkg::*;
(
  input  wire  [2:0]      i_funct3,
  input  wire  [6:0]      i_funct7,
  input  wire             i_word,    // addw/subw/sllw/srlw/sraw and immediate forms.
  input  wire             i_reg,     // register-register encoding.
  input  wire  [xlen-1:0] i_op1,
  input  wire  [xlen-1:0] i_op2,
  output logic [xlen-1:0] o_result
);

  logic            alt;
  logic            do_sub;
  logic [5:0]      shamt;
  logic [4:0]      shamt_w;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] sll_d;
  logic [xlen-1:0] srl_d;
  logic [xlen-1:0] sra_d;
  logic [31:0]     sll_w;
  logic [31:0]     srl_w;
  logic [31:0]     sra_w;
  logic            lt_s;
  logic            lt_u;
  logic [xlen-1:0] res_d;
  logic [31:0]     res_w;

  // bit 0 is ignored since rv64 immediate shifts carry shamt[5] there.
  assign alt    = (i_funct7[6:1] == f7_alt[6:1]);
  assign do_sub = i_reg & alt;          // addi has no subtract form.

  assign shamt   = i_op2[5:0];
  assign shamt_w = i_op2[4:0];

  assign sum = do_sub ? (i_op1 - i_op2) : (i_op1 + i_op2);

  assign sll_d = i_op1 << shamt;
  assign srl_d = i_op1 >> shamt;
  assign sra_d = $signed(i_op1) >>> shamt;

  assign sll_w = i_op1[31:0] << shamt_w;
  assign srl_w = i_op1[31:0] >> shamt_w;
  assign sra_w = $signed(i_op1[31:0]) >>> shamt_w;

  assign lt_s = $signed(i_op1) < $signed(i_op2);
  assign lt_u = i_op1 < i_op2;

  always_comb begin
    case (i_funct3)
      f3_add_sub: res_d = sum;
      f3_sll:     res_d = sll_d;
      f3_slt:     res_d = {{(xlen-1){1'b0}}, lt_s};
      f3_sltu:    res_d = {{(xlen-1){1'b0}}, lt_u};
      f3_xor:     res_d = i_op1 ^ i_op2;
      f3_srl_sra: res_d = alt ? sra_d : srl_d;
      f3_or:      res_d = i_op1 | i_op2;
      f3_and:     res_d = i_op1 & i_op2;
      default:    res_d = sum;
    endcase
  end

  // Only add, sub and the shifts exist in word form. The low half of the
  // 64-bit result is already correct for add and sub.
  always_comb begin
    case (i_funct3)
      f3_sll:     res_w = sll_w;
      f3_srl_sra: res_w = alt ? sra_w : srl_w;
      default:    res_w = res_d[31:0];
    endcase
  end

  assign o_result = i_word ? {{(xlen-32){res_w[31]}}, res_w} : res_d;

endmodule

`default_nettype wire

// ==== logic/branch_unit.sv ====
// Resolves the next pc of one instruction and compares it with the fetch prediction.
// Non-control instructions resolve to pc+4, so a wrong guess there also redirects.
`timescale 1ns/1ns
`default_nettype none

module branch_unit
  import exe_pkg::*;
(
  input  wire decoded_t   i_inst,
  output logic            o_pc_jmp,
  output logic [xlen-1:0] o_pc_jmpaddr,
  output logic [xlen-1:0] o_link
);

  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  logic            cond;
  logic [xlen-1:0] seq_pc;
  logic [xlen-1:0] jalr_sum;
  logic [xlen-1:0] next_pc;

  assign is_branch = (i_inst.opcode == op_branch);
  assign is_jal    = (i_inst.opcode == op_jal);
  assign is_jalr   = (i_inst.opcode == op_jalr);

  assign seq_pc   = i_inst.pc + 64'd4;
  assign jalr_sum = i_inst.op1 + i_inst.t1;

  always_comb begin
    case (i_inst.funct3)
      f3_beq:  cond = (i_inst.op1 == i_inst.op2);
      f3_bne:  cond = (i_inst.op1 != i_inst.op2);
      f3_blt:  cond = ($signed(i_inst.op1) < $signed(i_inst.op2));
      f3_bge:  cond = ($signed(i_inst.op1) >= $signed(i_inst.op2));
      f3_bltu: cond = (i_inst.op1 < i_inst.op2);
      f3_bgeu: cond = (i_inst.op1 >= i_inst.op2);
      default: cond = 1'b0;    // reserved encodings never take.
    endcase
  end

  always_comb begin
    if (is_jal || (is_branch && cond)) begin
      next_pc = i_inst.t1;
    end else if (is_jalr) begin
      next_pc = {jalr_sum[xlen-1:1], 1'b0};  // target lsb is dropped.
    end else begin
      next_pc = seq_pc;
    end
  end

  assign o_pc_jmp     = (next_pc != i_inst.pc_pred);
  assign o_pc_jmpaddr = next_pc;
  assign o_link       = seq_pc;

endmodule

`default_nettype wire

// ==== tests/exe_ref_model.svh ====
// Reference model of the execute stage, included inside the testbench module.
// Needs exe_pkg imported by the module that includes it.
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

function automatic executed_t exe_expect(input decoded_t d);
  executed_t   e;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] alu_r;
  logic [63:0] nxt;
  logic [31:0] w;
  logic        alt;
  logic        sub;
  logic        word;
  logic        taken;
  a     = d.op1;
  b     = d.op2;
  alt   = (d.funct7[6:1] == 6'b010000);  // funct7 bit 0 may carry shamt[5].
  sub   = alt && ((d.opcode == op_reg) || (d.opcode == op_reg_w));
  word  = (d.opcode == op_imm_w) || (d.opcode == op_reg_w);
  case (d.funct3)
    f3_add_sub: alu_r = sub ? a - b : a + b;
    f3_sll:     alu_r = a << b[5:0];
    f3_slt:     alu_r = {63'd0, $signed(a) < $signed(b)};
    f3_sltu:    alu_r = {63'd0, a < b};
    f3_xor:     alu_r = a ^ b;
    f3_srl_sra: begin
      if (alt) begin
        alu_r = $signed(a) >>> b[5:0];
      end else begin
        alu_r = a >> b[5:0];
      end
    end
    f3_or:      alu_r = a | b;
    default:    alu_r = a & b;
  endcase
  if (word) begin
    case (d.funct3)
      f3_add_sub: w = sub ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
      f3_sll:     w = a[31:0] << b[4:0];
      f3_srl_sra: begin
        if (alt) begin
          w = $signed(a[31:0]) >>> b[4:0];
        end else begin
          w = a[31:0] >> b[4:0];
        end
      end
      default:    w = alu_r[31:0];
    endcase
    alu_r = {{32{w[31]}}, w};
  end
  case (d.funct3)
    f3_beq:  taken = (a == b);
    f3_bne:  taken = (a != b);
    f3_blt:  taken = $signed(a) < $signed(b);
    f3_bge:  taken = $signed(a) >= $signed(b);
    f3_bltu: taken = a < b;
    f3_bgeu: taken = a >= b;
    default: taken = 1'b0;
  endcase
  nxt = d.pc + 64'd4;
  if ((d.opcode == op_jal) || ((d.opcode == op_branch) && taken)) begin
    nxt = d.t1;
  end
  if (d.opcode == op_jalr) begin
    nxt = (a + d.t1) & ~64'd1;
  end
  e.pc_jmp     = (nxt != d.pc_pred);
  e.pc_jmpaddr = nxt;
  e.rd_wen     = !((d.opcode == op_branch) || (d.opcode == op_store));
  if ((d.opcode == op_jal) || (d.opcode == op_jalr)) begin
    e.rd_wdata = d.pc + 64'd4;
  end else if ((d.opcode == op_lui) || (d.opcode == op_auipc)) begin
    e.rd_wdata = a + b;
  end else begin
    e.rd_wdata = alu_r;
  end
  e.memren   = d.memren;
  e.memwen   = d.memwen;
  e.mem_addr = a + b;
  return e;
endfunction

`endif

// ==== tests/tb_exe.sv ====
// Random traffic for exe_stage with downstream back-pressure and an in-order scoreboard.
// Needs --assert under Verilator, since the immediate assertions do all of the checking.
`timescale 1ns/1ns
`default_nettype none

module tb_exe
  import exe_pkg::*;
();

  localparam int          num_insts      = 600;
  localparam int          timeout_cycles = num_insts * 5;  // 4 cycles each at worst, plus slack.
  localparam logic [31:0] seed           = 32'hb81a914c;

  logic        clk;
  logic        rst;
  logic        i_decoded_req;
  decoded_t    i_decoded;
  logic        i_executed_ack = 1'b0;
  logic        o_decoded_ack;
  logic        o_executed_req;
  executed_t   o_executed;

  logic [2:0]  inst_kind;
  executed_t   exp_q[$];
  logic [2:0]  kind_q[$];
  executed_t   want;
  logic [2:0]  want_kind;
  executed_t   held;
  logic        was_stalled;
  logic        was_put;
  logic [31:0] stim_rng = seed;
  logic [31:0] ack_rng = seed ^ 32'h9e3779b9;
  logic [1:0]  stall_left = 2'd0;
  int          value_errors = 0;
  int          proto_errors = 0;
  int          end_errors = 0;
  int          received = 0;
  int          cycles = 0;

  `include "exe_ref_model.svh"

  exe_stage i_dut (
    .clk            (clk),
    .rst            (rst),
    .i_decoded_req  (i_decoded_req),
    .o_decoded_ack  (o_decoded_ack),
    .i_decoded      (i_decoded),
    .o_executed_req (o_executed_req),
    .i_executed_ack (i_executed_ack),
    .o_executed     (o_executed)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] stim_next();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic string kind_name(input logic [2:0] k);
    case (k)
      3'd0:    return "alu64";
      3'd1:    return "alu32";
      3'd2:    return "branch";
      3'd3:    return "jump";
      3'd4:    return "mem";
      default: return "upper";
    endcase
  endfunction

  task automatic gen_inst(output decoded_t d, output logic [2:0] kind);
    logic [31:0] sel;
    logic [31:0] r;
    sel       = stim_next();
    r         = stim_next();
    d         = '0;
    d.op1     = {stim_next(), stim_next()};
    d.op2     = {stim_next(), stim_next()};
    d.pc      = {stim_next(), stim_next()} & ~64'd3;
    d.pc_pred = d.pc + 64'd4;
    d.t1      = d.pc + sext12(r[23:12]);
    d.funct3  = sel[10:8];
    d.funct7  = sel[11] ? f7_alt : 7'd0;
    case (sel[3:0])
      4'd0, 4'd1, 4'd2, 4'd3: begin
        kind     = 3'd0;
        d.opcode = sel[4] ? op_reg : op_imm;
        if (!sel[4]) begin
          d.op2 = sext12(r[11:0]);
          if ((d.funct3 == f3_sll) || (d.funct3 == f3_srl_sra)) begin
            d.op2    = {58'd0, r[5:0]};
            d.funct7 = d.funct7 | {6'd0, r[5]};  // shamt[5] sits in funct7 bit 0.
          end
        end
      end
      4'd4, 4'd5, 4'd6: begin
        kind      = 3'd1;
        d.opcode  = sel[4] ? op_reg_w : op_imm_w;
        d.op1[31] = 1'b1;  // most word results then have bit 31 set.
        case (sel[9:8])
          2'd0:    d.funct3 = f3_add_sub;
          2'd1:    d.funct3 = f3_sll;
          default: d.funct3 = f3_srl_sra;
        endcase
        if (!sel[4]) begin
          d.op2 = (d.funct3 == f3_add_sub) ? sext12(r[11:0]) : {59'd0, r[4:0]};
        end
      end
      4'd7, 4'd8, 4'd9: begin
        kind     = 3'd2;
        d.opcode = op_branch;
        if (sel[10:9] == 2'b01) begin
          d.funct3 = {2'b00, sel[8]};  // the two unused codes become beq and bne.
        end
        if (sel[12]) begin
          d.op2 = d.op1;
        end
        if (sel[13]) begin
          d.pc_pred = d.t1;
        end
      end
      4'd10, 4'd11: begin
        kind = 3'd3;
        if (sel[4]) begin
          d.opcode = op_jal;
          if (sel[13]) begin
            d.pc_pred = d.t1;
          end
        end else begin
          d.opcode = op_jalr;
          d.t1     = sext12(r[11:0]);
          if (sel[13]) begin
            d.pc_pred = (d.op1 + d.t1) & ~64'd1;
          end
        end
      end
      4'd12, 4'd13: begin
        kind  = 3'd4;
        d.op2 = sext12(r[11:0]);
        if (sel[4]) begin
          d.opcode = op_load;
          d.memren = 1'b1;
        end else begin
          d.opcode = op_store;
          d.memwen = 1'b1;
        end
      end
      default: begin
        kind  = 3'd5;
        d.op2 = {{32{r[31]}}, r[31:12], 12'd0};
        if (sel[4]) begin
          d.opcode = op_lui;
          d.op1    = 64'd0;
        end else begin
          d.opcode = op_auipc;
          d.op1    = d.pc;
        end
      end
    endcase
  endtask

  task automatic finish_run(input logic timed_out);
    $display("errors: %0d value, %0d protocol, %0d end of run; %0d of %0d results received",
             value_errors, proto_errors, end_errors, received, num_insts);
    if (timed_out || (value_errors != 0) || (proto_errors != 0) || (end_errors != 0)) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  endtask

  // downstream consumer with random low periods of the ack.
  always @(posedge clk) begin
    ack_rng <= xorshift(ack_rng);
    if (rst) begin
      i_executed_ack <= 1'b0;
      stall_left     <= 2'd0;
    end else if (stall_left != 2'd0) begin
      i_executed_ack <= 1'b0;
      stall_left     <= stall_left - 2'd1;
    end else if (ack_rng[3:0] == 4'd0) begin
      i_executed_ack <= 1'b0;  // a low period of 1 to 4 cycles.
      stall_left     <= ack_rng[5:4];
    end else begin
      i_executed_ack <= (ack_rng[7:6] != 2'd0);
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      was_stalled <= 1'b0;
      was_put     <= 1'b0;
    end else begin
      if (o_executed_req && i_executed_ack) begin
        if (exp_q.size() == 0) begin
          proto_errors++;
          $display("queue empty at a downstream transfer");
        end else begin
          want      = exp_q.pop_front();
          want_kind = kind_q.pop_front();
          received++;
          assert (o_executed == want) else begin
            value_errors++;
            $display("FAIL %s expected %h actual %h", kind_name(want_kind), want, o_executed);
          end
        end
      end
      if (i_decoded_req && o_decoded_ack) begin
        exp_q.push_back(exe_expect(i_decoded));
        kind_q.push_back(inst_kind);
      end
      assert (!(o_executed_req && !i_executed_ack) || !o_decoded_ack) else begin
        proto_errors++;
        $display("o_decoded_ack is high while the slot is full and stalled");
      end
      if (was_stalled) begin
        assert (o_executed_req && (o_executed == held)) else begin
          proto_errors++;
          $display("o_executed changed or was dropped while stalled");
        end
      end
      if (was_put) begin
        assert (o_executed_req) else begin
          proto_errors++;
          $display("o_executed_req is not high one cycle after acceptance");
        end
      end
      was_stalled <= o_executed_req && !i_executed_ack;
      was_put     <= i_decoded_req && o_decoded_ack;
    end
    held <= o_executed;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: the run did not end within %0d cycles", timeout_cycles);
      finish_run(1'b1);
    end
  end

  initial begin
    decoded_t   d;
    logic [2:0] kind;
    int         issued;
    int         accepted;
    int         drain;
    issued        = 0;
    accepted      = 0;
    drain         = 0;
    rst           <= 1'b1;
    i_decoded_req <= 1'b0;
    i_decoded     <= '0;
    inst_kind     <= 3'd0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (!o_executed_req && o_decoded_ack) else begin
      end_errors++;
      $display("after reset the stage is not empty and ready");
    end
    assert (!(o_executed.pc_jmp | o_executed.rd_wen | o_executed.memren | o_executed.memwen))
    else begin
      end_errors++;
      $display("control fields of o_executed are not low after reset");
    end
    while (accepted < num_insts) begin
      @(posedge clk);
      if (i_decoded_req && o_decoded_ack) begin
        accepted++;
      end
      if (!i_decoded_req || o_decoded_ack) begin
        if ((issued < num_insts) && ((stim_next() & 32'd7) != 32'd0)) begin
          gen_inst(d, kind);
          i_decoded     <= d;
          inst_kind     <= kind;
          i_decoded_req <= 1'b1;
          issued++;
        end else begin
          i_decoded_req <= 1'b0;
        end
      end
    end
    @(negedge clk);  // the scoreboard has pushed the last accepted instruction by now.
    while ((exp_q.size() != 0) && (drain < 64)) begin
      @(negedge clk);
      drain++;
    end
    if (exp_q.size() != 0) begin
      end_errors++;
      $display("%0d instructions left unconsumed at the end", exp_q.size());
    end
    if (received != num_insts) begin
      end_errors++;
      $display("received %0d results but sent %0d instructions", received, num_insts);
    end
    finish_run(1'b0);
  end

endmodule

`default_nettype wire
